// File: mips_lite.f
+incdir+.
mips_lite_pkg.sv
stage_if.sv
main_control.sv
insn_fetch.sv
if_id_reg.sv
exec_stage.sv
mips_lite_top.sv
tb_mips_lite.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_mips_lite -Mdir "$BUILD_DIR" -f mips_lite.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_mips_lite" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
exit 0

// File: tb_mips_lite.sv
`timescale 1ns/10ps

`include "mips_lite_cfg.svh"

module tb_mips_lite;

  localparam int IMEM_AW      = $clog2(`MIPS_LITE_IMEM_DEPTH);
  localparam int N_TESTS      = 27;
  localparam int CYCLE_LIMIT  = 4 * N_TESTS + 40;
  localparam int QUIET_CYCLES = 8;

  typedef enum logic [3:0] {
    EV_NONE  = 4'd0,
    EV_WB    = 4'd1,
    EV_STORE = 4'd2
  } ev_kind_t;

  logic               clk;
  logic               rst_n;
  logic               run;
  logic               imem_we;
  logic [IMEM_AW-1:0] imem_addr;
  logic [31:0]        imem_wdata;
  logic               wb_valid;
  logic [4:0]         wb_reg;
  logic [31:0]        wb_data;
  logic               st_valid;
  logic [31:0]        st_addr;
  logic [31:0]        st_data;

  string       test_name [N_TESTS];
  logic [31:0] insn_word [N_TESTS];
  ev_kind_t    exp_kind  [N_TESTS];
  logic [31:0] exp_key   [N_TESTS];
  logic [31:0] exp_value [N_TESTS];

  int n_entries   = 0;
  int n_events    = 0;
  int next_entry  = 0;
  int events_seen = 0;
  int pass_count  = 0;
  int fail_count  = 0;
  int run_cycles  = 0;

  mips_lite_top mips_lite_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data),
    .st_valid   (st_valid),
    .st_addr    (st_addr),
    .st_data    (st_data)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction encoders and program table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] enc_i(logic [5:0] op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] enc_r(logic [5:0] funct, int rd, int rs, int rt);
    return {6'd0, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
  endfunction

  function automatic logic [31:0] enc_j(logic [5:0] op, int target);
    return {op, target[25:0]};
  endfunction

  // filler words carry an undecoded opcode.
  function automatic logic [31:0] fill_word(int addr);
    return {6'h3f, addr[25:0]};
  endfunction

  task automatic add_entry(input string name, input logic [31:0] word, input ev_kind_t kind,
                           input logic [31:0] key, input logic [31:0] value);
    test_name[n_entries] = name;
    insn_word[n_entries] = word;
    exp_kind[n_entries]  = kind;
    exp_key[n_entries]   = key;
    exp_value[n_entries] = value;
    if (kind != EV_NONE) begin
      n_events++;
    end
    n_entries++;
  endtask

  task automatic build_table();
    add_entry("addi r1 r0 5", enc_i(mips_lite_pkg::OP_ADDI, 0, 1, 'h0005), EV_WB, 1, 'h5);
    add_entry("ori r2 r0 8001", enc_i(mips_lite_pkg::OP_ORI, 0, 2, 'h8001), EV_WB, 2, 'h8001);
    add_entry("xori r4 r1 ffff", enc_i(mips_lite_pkg::OP_XORI, 1, 4, 'hffff), EV_WB, 4, 'hfffa);
    add_entry("slti r5 r1 -1", enc_i(mips_lite_pkg::OP_SLTI, 1, 5, 'hffff), EV_WB, 5, 'h0);
    add_entry("addi r6 r0 -3", enc_i(mips_lite_pkg::OP_ADDI, 0, 6, 'hfffd), EV_WB, 6, 'hfffffffd);
    add_entry("andi r3 r6 80ff", enc_i(mips_lite_pkg::OP_ANDI, 6, 3, 'h80ff), EV_WB, 3, 'h80fd);
    add_entry("slti r7 r6 -1", enc_i(mips_lite_pkg::OP_SLTI, 6, 7, 'hffff), EV_WB, 7, 'h1);
    add_entry("add r8 r1 r6", enc_r(mips_lite_pkg::FN_ADD, 8, 1, 6), EV_WB, 8, 'h2);
    add_entry("sub r9 r1 r6", enc_r(mips_lite_pkg::FN_SUB, 9, 1, 6), EV_WB, 9, 'h8);
    add_entry("and r10 r2 r4", enc_r(mips_lite_pkg::FN_AND, 10, 2, 4), EV_WB, 10, 'h8000);
    add_entry("or r11 r1 r2", enc_r(mips_lite_pkg::FN_OR, 11, 1, 2), EV_WB, 11, 'h8005);
    add_entry("xor r12 r1 r4", enc_r(mips_lite_pkg::FN_XOR, 12, 1, 4), EV_WB, 12, 'hffff);
    add_entry("slt r13 r6 r1", enc_r(mips_lite_pkg::FN_SLT, 13, 6, 1), EV_WB, 13, 'h1);
    add_entry("add r0 r1 r1", enc_r(mips_lite_pkg::FN_ADD, 0, 1, 1), EV_NONE, 0, 0);
    add_entry("add r14 r0 r1", enc_r(mips_lite_pkg::FN_ADD, 14, 0, 1), EV_WB, 14, 'h5);
    add_entry("sw r11 6(r8)", enc_i(mips_lite_pkg::OP_SW, 8, 11, 'h0006), EV_STORE, 8, 'h8005);
    add_entry("lw r15 8(r0)", enc_i(mips_lite_pkg::OP_LW, 0, 15, 'h0008), EV_WB, 15, 'h8005);
    add_entry("beq r1 r14 taken", enc_i(mips_lite_pkg::OP_BEQ, 1, 14, 'h0001), EV_NONE, 0, 0);
    add_entry("addi r16 skipped", enc_i(mips_lite_pkg::OP_ADDI, 0, 16, 'h0063), EV_NONE, 0, 0);
    add_entry("beq r1 r2 fall", enc_i(mips_lite_pkg::OP_BEQ, 1, 2, 'h0001), EV_NONE, 0, 0);
    add_entry("addi r17 r0 7", enc_i(mips_lite_pkg::OP_ADDI, 0, 17, 'h0007), EV_WB, 17, 'h7);
    add_entry("j 24", enc_j(mips_lite_pkg::OP_J, 24), EV_NONE, 0, 0);
    add_entry("addi r18 skipped", enc_i(mips_lite_pkg::OP_ADDI, 0, 18, 'h0001), EV_NONE, 0, 0);
    add_entry("addi r19 skipped", enc_i(mips_lite_pkg::OP_ADDI, 0, 19, 'h0002), EV_NONE, 0, 0);
    add_entry("jal unused", enc_j(6'b000011, 0), EV_NONE, 0, 0);
    add_entry("addi r20 r0 1234", enc_i(mips_lite_pkg::OP_ADDI, 0, 20, 'h1234), EV_WB, 20, 'h1234);
    // jumps to itself so the core idles at the end.
    add_entry("j 26 halt", enc_j(mips_lite_pkg::OP_J, 26), EV_NONE, 0, 0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic compare_values(input string name, input logic [67:0] expected,
                                input logic [67:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      fail_count++;
    end else begin
      $display("ok %s: %h", name, actual);
      pass_count++;
    end
  endtask

  task automatic match_event(input ev_kind_t kind, input logic [31:0] key,
                             input logic [31:0] value);
    while (next_entry < N_TESTS && exp_kind[next_entry] == EV_NONE) begin
      next_entry++;
    end
    if (!rst_n || !run) begin
      $display("ERROR: the core reported a result while in reset or idle (%h %h)", key, value);
      fail_count++;
    end else if (next_entry >= N_TESTS) begin
      $display("ERROR: an extra result appeared after the last expected one (%h %h)",
               key, value);
      fail_count++;
    end else begin
      compare_values(test_name[next_entry],
                     {exp_kind[next_entry], exp_key[next_entry], exp_value[next_entry]},
                     {kind, key, value});
      next_entry++;
      events_seen++;
    end
  endtask

  // outputs settle after the rising edge, so they are sampled on the falling one.
  always @(negedge clk) begin
    if (wb_valid) begin
      match_event(EV_WB, {27'd0, wb_reg}, wb_data);
    end
    if (st_valid) begin
      match_event(EV_STORE, st_addr, st_data);
    end
  end

  task automatic load_program();
    for (int a = 0; a < `MIPS_LITE_IMEM_DEPTH; a++) begin
      imem_we    <= 1'b1;
      imem_addr  <= IMEM_AW'(a);
      imem_wdata <= (a < N_TESTS) ? insn_word[a] : fill_word(a);
      @(posedge clk);
    end
    imem_we <= 1'b0;
  endtask

  initial begin
    rst_n      = 1'b0;
    run        = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = 32'd0;
    build_table();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    load_program();
    // a short idle window with run low.
    repeat (4) @(posedge clk);
    run <= 1'b1;
    while (events_seen < n_events && run_cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      run_cycles++;
    end
    if (events_seen < n_events) begin
      $display("ERROR: the program did not finish within %0d cycles", CYCLE_LIMIT);
      fail_count++;
    end else begin
      repeat (QUIET_CYCLES) @(posedge clk);
    end
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: mips_lite_top.sv
`timescale 1ns/10ps

`include "mips_lite_cfg.svh"

module mips_lite_top #(
  parameter int IMEM_AW = $clog2(`MIPS_LITE_IMEM_DEPTH)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  input  logic               imem_we,
  input  logic [IMEM_AW-1:0] imem_addr,
  input  logic [31:0]        imem_wdata,
  output logic               wb_valid,
  output logic [4:0]         wb_reg,
  output logic [31:0]        wb_data,
  output logic               st_valid,
  output logic [31:0]        st_addr,
  output logic [31:0]        st_data
);

  logic        redirect;
  logic [31:0] redirect_pc;

  stage_if fetch_to_buf ();
  stage_if buf_to_exec ();

  insn_fetch #(
    .IMEM_AW (IMEM_AW)
  ) insn_fetch_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_wdata  (imem_wdata),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .out         (fetch_to_buf.producer)
  );

  if_id_reg if_id_reg_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .redirect (redirect),
    .in       (fetch_to_buf.consumer),
    .out      (buf_to_exec.producer)
  );

  exec_stage exec_stage_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .in          (buf_to_exec.consumer),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .wb_valid    (wb_valid),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data),
    .st_valid    (st_valid),
    .st_addr     (st_addr),
    .st_data     (st_data)
  );

endmodule

// File: exec_stage.sv
`timescale 1ns/10ps

`include "mips_lite_cfg.svh"

module exec_stage (
  input  logic        clk,
  input  logic        rst_n,
  stage_if.consumer   in,
  output logic        redirect,
  output logic [31:0] redirect_pc,
  output logic        wb_valid,
  output logic [4:0]  wb_reg,
  output logic [31:0] wb_data,
  output logic        st_valid,
  output logic [31:0] st_addr,
  output logic [31:0] st_data
);

  localparam int DMEM_AW = $clog2(`MIPS_LITE_DMEM_DEPTH);
  // not decoded by main_control, so a bubble does nothing.
  localparam logic [5:0] OP_IDLE = 6'h3f;

  mips_lite_pkg::insn_t       insn;
  logic [5:0]                 opcode;
  logic                       branch_eq;
  mips_lite_pkg::pc_source_t  pc_source;
  logic                       imm_command;
  logic                       alu_src_b;
  logic                       dst_reg_sel;
  mips_lite_pkg::alu_op_t     alu_op;
  logic                       mem_read;
  logic                       mem_write;
  logic                       mem_to_reg;
  logic                       reg_write;
  logic [31:0]                regs [32];
  logic [31:0]                dmem [`MIPS_LITE_DMEM_DEPTH];
  logic [31:0]                rs_data;
  logic [31:0]                rt_data;
  logic [31:0]                imm_sext;
  logic [31:0]                imm_ext;
  logic [31:0]                alu_b;
  logic [31:0]                alu_res;
  logic [31:0]                mem_rdata;
  logic [5:0]                 alu_sel;

  assign insn   = in.insn;
  assign opcode = in.valid ? insn.r.opcode : OP_IDLE;

  main_control main_control_inst (
    .opcode         (opcode),
    .branch_eq      (branch_eq),
    .if_pc_source   (pc_source),
    .ex_imm_command (imm_command),
    .ex_alu_src_b   (alu_src_b),
    .ex_dst_reg_sel (dst_reg_sel),
    .ex_alu_op      (alu_op),
    .mem_read       (mem_read),
    .mem_write      (mem_write),
    .wb_mem_to_reg  (mem_to_reg),
    .wb_reg_write   (reg_write)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operands
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rs_data   = (insn.r.rs == 5'd0) ? 32'd0 : regs[insn.r.rs];
  assign rt_data   = (insn.r.rt == 5'd0) ? 32'd0 : regs[insn.r.rt];
  assign branch_eq = (rs_data == rt_data);

  // logical immediates are zero extended.
  assign imm_sext = {{16{insn.i.imm[15]}}, insn.i.imm};
  assign imm_ext  = ((opcode == mips_lite_pkg::OP_ANDI) || (opcode == mips_lite_pkg::OP_ORI) ||
                     (opcode == mips_lite_pkg::OP_XORI)) ? {16'd0, insn.i.imm} : imm_sext;
  assign alu_b    = alu_src_b ? imm_ext : rt_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // alu
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // immediate opcodes are mapped onto the matching funct code.
  always_comb begin
    case (opcode)
      mips_lite_pkg::OP_ANDI: alu_sel = mips_lite_pkg::FN_AND;
      mips_lite_pkg::OP_ORI:  alu_sel = mips_lite_pkg::FN_OR;
      mips_lite_pkg::OP_XORI: alu_sel = mips_lite_pkg::FN_XOR;
      mips_lite_pkg::OP_SLTI: alu_sel = mips_lite_pkg::FN_SLT;
      default:                alu_sel = mips_lite_pkg::FN_ADD;
    endcase
    if (!imm_command) begin
      alu_sel = insn.r.funct;
    end
  end

  always_comb begin
    case (alu_op)
      mips_lite_pkg::ALU_ADD: alu_res = rs_data + alu_b;
      mips_lite_pkg::ALU_SUB: alu_res = rs_data - alu_b;
      mips_lite_pkg::ALU_BY_FUNCT: begin
        case (alu_sel)
          mips_lite_pkg::FN_ADD: alu_res = rs_data + alu_b;
          mips_lite_pkg::FN_SUB: alu_res = rs_data - alu_b;
          mips_lite_pkg::FN_AND: alu_res = rs_data & alu_b;
          mips_lite_pkg::FN_OR:  alu_res = rs_data | alu_b;
          mips_lite_pkg::FN_XOR: alu_res = rs_data ^ alu_b;
          mips_lite_pkg::FN_SLT: alu_res = {31'd0, $signed(rs_data) < $signed(alu_b)};
          default:               alu_res = 32'd0;
        endcase
      end
      default: alu_res = 32'd0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // redirect, memory and writeback
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign redirect    = (pc_source != mips_lite_pkg::PC_SEQ);
  assign redirect_pc = (pc_source == mips_lite_pkg::PC_JUMP) ?
                       {in.pc_plus4[31:28], insn.j.target, 2'b00} :
                       in.pc_plus4 + {imm_sext[29:0], 2'b00};

  assign mem_rdata = mem_read ? dmem[alu_res[DMEM_AW+1:2]] : 32'd0;

  always_ff @(posedge clk) begin
    if (mem_write) begin
      dmem[alu_res[DMEM_AW+1:2]] <= rt_data;
    end
  end

  assign wb_reg   = dst_reg_sel ? insn.r.rd : insn.r.rt;
  assign wb_valid = reg_write && (wb_reg != 5'd0);
  assign wb_data  = mem_to_reg ? mem_rdata : alu_res;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wb_valid) begin
      regs[wb_reg] <= wb_data;
    end
  end

  assign st_valid = mem_write;
  assign st_addr  = alu_res;
  assign st_data  = rt_data;

  // the decoder never asks for a load and a store at once.
  a_mem_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(mem_read && mem_write)
  );

endmodule

// File: if_id_reg.sv
`timescale 1ns/10ps

module if_id_reg (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      redirect,
  stage_if.consumer in,
  stage_if.producer out
);

  logic                 valid_q;
  logic [31:0]          pc_plus4_q;
  mips_lite_pkg::insn_t insn_q;

  // a redirect turns the younger fetch into a bubble.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in.valid && !redirect;
    end
  end

  always_ff @(posedge clk) begin
    pc_plus4_q <= in.pc_plus4;
    insn_q     <= in.insn;
  end

  assign out.valid    = valid_q;
  assign out.pc_plus4 = pc_plus4_q;
  assign out.insn     = insn_q;

  // only a valid instruction redirects, and a bubble follows it.
  a_squash_after_redirect: assert property (
    @(posedge clk) disable iff (!rst_n) redirect |=> (!out.valid && $past(out.valid))
  );

endmodule

// File: insn_fetch.sv
`timescale 1ns/10ps

`include "mips_lite_cfg.svh"

module insn_fetch #(
  parameter int IMEM_AW = $clog2(`MIPS_LITE_IMEM_DEPTH)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  input  logic               imem_we,
  input  logic [IMEM_AW-1:0] imem_addr,
  input  logic [31:0]        imem_wdata,
  input  logic               redirect,
  input  logic [31:0]        redirect_pc,
  stage_if.producer          out
);

  logic [31:0] pc;
  logic [31:0] pc_plus4;
  logic [31:0] imem [`MIPS_LITE_IMEM_DEPTH];

  assign pc_plus4 = pc + 32'd4;

  // pc holds while the core is stopped.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `MIPS_LITE_RESET_PC;
    end else if (run) begin
      pc <= redirect ? redirect_pc : pc_plus4;
    end
  end

  // loaded by the testbench before run goes high.
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  assign out.insn     = imem[pc[IMEM_AW+1:2]];
  assign out.pc_plus4 = pc_plus4;
  assign out.valid    = run;

  // program loading and execution never overlap.
  a_no_load_while_running: assert property (
    @(posedge clk) disable iff (!rst_n) !(imem_we && run)
  );

endmodule

// File: main_control.sv
`timescale 1ns/10ps

module main_control (
  input  logic                      [5:0] opcode,
  input  logic                            branch_eq,
  output mips_lite_pkg::pc_source_t       if_pc_source,
  output logic                            ex_imm_command,
  output logic                            ex_alu_src_b,
  output logic                            ex_dst_reg_sel,
  output mips_lite_pkg::alu_op_t          ex_alu_op,
  output logic                            mem_read,
  output logic                            mem_write,
  output logic                            wb_mem_to_reg,
  output logic                            wb_reg_write
);

  logic memory_op;
  logic r_type_op;
  logic immediate_op;
  logic branch_op;
  logic jump_op;

  always_comb begin
    memory_op    = (opcode == mips_lite_pkg::OP_LW) || (opcode == mips_lite_pkg::OP_SW);
    r_type_op    = (opcode == mips_lite_pkg::OP_RTYPE);
    branch_op    = (opcode == mips_lite_pkg::OP_BEQ);
    jump_op      = (opcode == mips_lite_pkg::OP_J);
    immediate_op = (opcode == mips_lite_pkg::OP_ADDI) || (opcode == mips_lite_pkg::OP_ANDI) ||
                   (opcode == mips_lite_pkg::OP_ORI)  || (opcode == mips_lite_pkg::OP_XORI) ||
                   (opcode == mips_lite_pkg::OP_SLTI);

    // everything idle unless a class below claims the opcode.
    if_pc_source   = mips_lite_pkg::PC_SEQ;
    ex_imm_command = immediate_op;
    ex_alu_src_b   = 1'b0;
    ex_dst_reg_sel = 1'b0;
    ex_alu_op      = mips_lite_pkg::ALU_ADD;
    mem_read       = 1'b0;
    mem_write      = 1'b0;
    wb_mem_to_reg  = 1'b0;
    wb_reg_write   = 1'b0;

    if (memory_op) begin
      ex_alu_src_b  = 1'b1;
      wb_mem_to_reg = 1'b1;
      if (opcode == mips_lite_pkg::OP_LW) begin
        mem_read     = 1'b1;
        wb_reg_write = 1'b1;
      end else begin
        mem_write = 1'b1;
      end
    end else if (r_type_op) begin
      ex_dst_reg_sel = 1'b1;
      ex_alu_op      = mips_lite_pkg::ALU_BY_FUNCT;
      wb_reg_write   = 1'b1;
    end else if (immediate_op) begin
      ex_alu_src_b = 1'b1;
      ex_alu_op    = mips_lite_pkg::ALU_BY_FUNCT;
      wb_reg_write = 1'b1;
    end else if (branch_op) begin
      if (branch_eq) begin
        if_pc_source = mips_lite_pkg::PC_BRANCH;
      end
    end else if (jump_op) begin
      if_pc_source = mips_lite_pkg::PC_JUMP;
    end
  end

endmodule

// File: stage_if.sv
`timescale 1ns/10ps

interface stage_if;

  logic [31:0]          pc_plus4;
  mips_lite_pkg::insn_t insn;
  logic                 valid;

  modport producer (
    output pc_plus4,
    output insn,
    output valid
  );

  modport consumer (
    input pc_plus4,
    input insn,
    input valid
  );

endinterface

// File: mips_lite_pkg.sv
package mips_lite_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcodes and function codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  parameter logic [5:0] OP_LW    = 6'b100011;
  parameter logic [5:0] OP_SW    = 6'b101011;
  parameter logic [5:0] OP_BEQ   = 6'b000100;
  parameter logic [5:0] OP_RTYPE = 6'b000000;
  parameter logic [5:0] OP_J     = 6'd2;
  parameter logic [5:0] OP_ADDI  = 6'b001000;
  parameter logic [5:0] OP_ANDI  = 6'b001100;
  parameter logic [5:0] OP_ORI   = 6'b001101;
  parameter logic [5:0] OP_XORI  = 6'b001110;
  parameter logic [5:0] OP_SLTI  = 6'b001010;

  parameter logic [5:0] FN_ADD = 6'b100000;
  parameter logic [5:0] FN_SUB = 6'b100010;
  parameter logic [5:0] FN_AND = 6'b100100;
  parameter logic [5:0] FN_OR  = 6'b100101;
  parameter logic [5:0] FN_XOR = 6'b100110;
  parameter logic [5:0] FN_SLT = 6'b101010;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    ALU_ADD      = 2'b00,
    ALU_SUB      = 2'b01,
    ALU_BY_FUNCT = 2'b10
  } alu_op_t;

  typedef enum logic [1:0] {
    PC_SEQ    = 2'b00,
    PC_BRANCH = 2'b01,
    PC_JUMP   = 2'b10
  } pc_source_t;

  // one instruction word, seen through the three encodings.
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] target;
    } j;
  } insn_t;

endpackage

// File: mips_lite_cfg.svh
`ifndef MIPS_LITE_CFG_SVH
`define MIPS_LITE_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// instruction words held by the fetch stage.
`define MIPS_LITE_IMEM_DEPTH 64

// data words behind lw and sw.
`define MIPS_LITE_DMEM_DEPTH 64

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reset state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define MIPS_LITE_RESET_PC 32'h0000_0000

`endif
